//--- Makefile
# Verilator flow for the packet switch testbench
# Override on the command line, e.g. make sim SIM_TIMEOUT=300 LOG=run.log

VERILATOR   ?= verilator
TOP         ?= tb_packet_switch
FILELIST    ?= all.f
LOG         ?= sim.log
OBJ_DIR     ?= obj_dir
SIM_TIMEOUT ?= 120
VFLAGS      ?= --timing --assert

SOURCES := $(FILELIST) $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-timeout $(SIM_TIMEOUT) ./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+hw
hw/switch_pkg.sv
hw/pkt_fifo.sv
hw/tx_queue.sv
hw/output_arbiter.sv
hw/crossbar.sv
hw/packet_switch.sv
testbench/tb_packet_switch.sv

//--- hw/crossbar.sv
/* Outputs always accept; data is taken from the queue output register one
   cycle after the grant */
`timescale 1ns/1ps
`include "switch_cfg.svh"

module crossbar (
  input  logic                                          clk,
  input  logic                                          rst,
  input  switch_pkg::port_mask_t                        tx_valid,
  input  switch_pkg::payload_t [`SWITCH_PORTS-1:0]      tx_data,
  input  switch_pkg::port_mask_t                        win_valid,
  input  switch_pkg::port_id_t [`SWITCH_PORTS-1:0]      win_index,
  output switch_pkg::port_mask_t                        out_valid,
  output switch_pkg::port_id_t [`SWITCH_PORTS-1:0]      out_source,
  output switch_pkg::payload_t [`SWITCH_PORTS-1:0]      out_data
);

  //////////////////////////////////////////////////////////////////////
  // One registered mux per output
  //////////////////////////////////////////////////////////////////////

  for (genvar j = 0; j < `SWITCH_PORTS; j++) begin : g_out

    // Valid follows the arbiter's winner flag
    always_ff @(posedge clk) begin
      if (rst)
        out_valid[j] <= 1'b0;
      else
        out_valid[j] <= win_valid[j];
    end

    // Data and source from the winning queue
    always_ff @(posedge clk) begin
      if (win_valid[j]) begin
        out_data[j]   <= tx_data[win_index[j]];
        // Source is the queue index itself
        out_source[j] <= win_index[j];
      end
    end

    // Winning queue has its packet loaded
    a_src_loaded : assert property (@(posedge clk) disable iff (rst)
      win_valid[j] |-> tx_valid[win_index[j]]);

  end

endmodule

//--- hw/output_arbiter.sv
/* Grant is combinational in the request cycle; winner and win_valid are
   registered on the edge that ends it */
`timescale 1ns/1ps
`include "switch_cfg.svh"

module output_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  switch_pkg::port_mask_t req,
  output switch_pkg::port_mask_t grant,
  output logic                   win_valid,
  output switch_pkg::port_id_t   win_index
);

  // First port searched is one past the last winner
  switch_pkg::port_id_t ptr;

  // Combinational pick
  switch_pkg::port_id_t pick;
  logic                 found;

  //////////////////////////////////////////////////////////////////////
  // Round-robin search
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    switch_pkg::port_id_t idx;
    found = 1'b0;
    pick  = ptr;
    idx   = ptr;
    // Walk upward from ptr and wrap at the port width
    for (int k = 0; k < `SWITCH_PORTS; k++) begin
      idx = ptr + switch_pkg::port_id_t'(k);
      if (!found && req[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
    end
  end

  // One-hot grant of the pick
  always_comb begin
    grant = '0;
    if (found)
      grant[pick] = 1'b1;
  end

  // Pointer moves only on a grant
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr       <= '0;
      win_valid <= 1'b0;
    end else begin
      win_valid <= found;
      if (found)
        ptr <= pick + 1'b1;
    end
  end

  // Winner index for the crossbar in the next cycle
  always_ff @(posedge clk) begin
    if (found)
      win_index <= pick;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_grant_onehot : assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant));

  // Never grant a port that is not asking
  a_grant_subset : assert property (@(posedge clk) disable iff (rst)
    (grant & ~req) == '0);

endmodule

//--- hw/packet_switch.sv
/* No output back-pressure; out_valid rises two clock edges after the edge
   that writes an uncontended packet into its input FIFO */
`timescale 1ns/1ps
`include "switch_cfg.svh"

module packet_switch (
  input  logic                                     clk,
  input  logic                                     rst,
  input  switch_pkg::port_mask_t                   in_valid,
  input  switch_pkg::port_id_t [`SWITCH_PORTS-1:0] in_dest,
  input  switch_pkg::payload_t [`SWITCH_PORTS-1:0] in_data,
  output switch_pkg::port_mask_t                   in_full,
  output switch_pkg::port_mask_t                   out_valid,
  output switch_pkg::port_id_t [`SWITCH_PORTS-1:0] out_source,
  output switch_pkg::payload_t [`SWITCH_PORTS-1:0] out_data
);

  // Queue side
  switch_pkg::port_mask_t                   req_valid;
  switch_pkg::port_id_t [`SWITCH_PORTS-1:0] req_dest;
  switch_pkg::port_mask_t                   q_grant;
  switch_pkg::port_mask_t                   tx_valid;
  switch_pkg::port_id_t [`SWITCH_PORTS-1:0] tx_dest;
  switch_pkg::payload_t [`SWITCH_PORTS-1:0] tx_data;

  // Arbiter side, indexed by output
  switch_pkg::port_mask_t [`SWITCH_PORTS-1:0] req_row;
  switch_pkg::port_mask_t [`SWITCH_PORTS-1:0] arb_grant;
  switch_pkg::port_mask_t                     win_valid;
  switch_pkg::port_id_t [`SWITCH_PORTS-1:0]   win_index;

  //////////////////////////////////////////////////////////////////////
  // Request matrix and grant columns
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int j = 0; j < `SWITCH_PORTS; j++)
      for (int i = 0; i < `SWITCH_PORTS; i++)
        req_row[j][i] = req_valid[i] && (req_dest[i] == switch_pkg::port_id_t'(j));
  end

  // Each input asks one output, so at most one term is set
  always_comb begin
    q_grant = '0;
    for (int i = 0; i < `SWITCH_PORTS; i++)
      for (int j = 0; j < `SWITCH_PORTS; j++)
        q_grant[i] = q_grant[i] | arb_grant[j][i];
  end

  for (genvar p = 0; p < `SWITCH_PORTS; p++) begin : g_port
    tx_queue u_txq (
      .clk (clk), .rst (rst),
      .in_valid (in_valid[p]), .in_dest (in_dest[p]), .in_data (in_data[p]),
      .grant (q_grant[p]), .in_full (in_full[p]),
      .req_valid (req_valid[p]), .req_dest (req_dest[p]),
      .tx_valid (tx_valid[p]), .tx_dest (tx_dest[p]), .tx_data (tx_data[p])
    );

    output_arbiter u_arb (
      .clk (clk), .rst (rst), .req (req_row[p]), .grant (arb_grant[p]),
      .win_valid (win_valid[p]), .win_index (win_index[p])
    );

    // Loaded queue packet is claimed by the arbiter of its destination
    a_tx_claimed : assert property (@(posedge clk) disable iff (rst)
      tx_valid[p] |-> (win_valid[tx_dest[p]] &&
                       (win_index[tx_dest[p]] == switch_pkg::port_id_t'(p))));
  end

  crossbar u_xbar (
    .clk (clk), .rst (rst),
    .tx_valid (tx_valid), .tx_data (tx_data),
    .win_valid (win_valid), .win_index (win_index),
    .out_valid (out_valid), .out_source (out_source), .out_data (out_data)
  );

endmodule

//--- hw/pkt_fifo.sv
/* Head word is valid whenever empty is low; a write while full is legal only
   together with a read */
`timescale 1ns/1ps
`include "switch_cfg.svh"

module pkt_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  switch_pkg::port_id_t   wr_dest,
  input  switch_pkg::payload_t   wr_data,
  output switch_pkg::port_id_t   rd_dest,
  output switch_pkg::payload_t   rd_data,
  output logic                   empty,
  output logic                   full,
  output switch_pkg::fifo_level_t level
);

  localparam int ADDR_W = $clog2(`SWITCH_FIFO_DEPTH);

  // Storage, split into destination and payload
  switch_pkg::port_id_t mem_dest [`SWITCH_FIFO_DEPTH];
  switch_pkg::payload_t mem_data [`SWITCH_FIFO_DEPTH];

  // Pointers wrap on their own since depth is a power of two
  logic [ADDR_W-1:0]       wr_ptr;
  logic [ADDR_W-1:0]       rd_ptr;
  switch_pkg::fifo_level_t count;

  assign empty = (count == '0);
  assign full  = (count == switch_pkg::fifo_level_t'(`SWITCH_FIFO_DEPTH));
  assign level = count;

  // Head word falls through
  assign rd_dest = mem_dest[rd_ptr];
  assign rd_data = mem_data[rd_ptr];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_dest[wr_ptr] <= wr_dest;
      mem_data[wr_ptr] <= wr_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous read and write keeps the count
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (rd_en && !wr_en)
        count <= count - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Underflow
  a_no_read_empty : assert property (@(posedge clk) disable iff (rst)
    rd_en |-> !empty);

  // Overflow, unless the head leaves in the same cycle
  a_no_write_full : assert property (@(posedge clk) disable iff (rst)
    (wr_en && full) |-> rd_en);

endmodule

//--- hw/switch_cfg.svh
/* Port count and FIFO depth must be powers of two
   SWITCH_PORT_W has to equal log2 of SWITCH_PORTS */
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// Number of input and output ports
`define SWITCH_PORTS 4

// Bits of a port number
`define SWITCH_PORT_W 2

// Words held by each input FIFO
`define SWITCH_FIFO_DEPTH 8

// Payload width in bits
`define SWITCH_DATA_W 16

`endif

//--- hw/switch_pkg.sv
/* Types only; all widths come from the configuration header */
`include "switch_cfg.svh"

package switch_pkg;

  // Port number, used for destination, source and winner
  typedef logic [`SWITCH_PORT_W-1:0] port_id_t;

  // Single-word packet payload
  typedef logic [`SWITCH_DATA_W-1:0] payload_t;

  // One bit per port
  typedef logic [`SWITCH_PORTS-1:0] port_mask_t;

  // FIFO occupancy, zero up to full depth
  typedef logic [$clog2(`SWITCH_FIFO_DEPTH):0] fifo_level_t;

  // Transmit queue state
  typedef enum logic [1:0] {
    Q_IDLE,
    Q_REQ,
    Q_SEND
  } queue_state_t;

endpackage

//--- hw/tx_queue.sv
/* Single FIFO per input; the sender must hold valid low while in_full is high
   Grant must only come while req_valid is high */
`timescale 1ns/1ps

module tx_queue (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  switch_pkg::port_id_t in_dest,
  input  switch_pkg::payload_t in_data,
  input  logic                 grant,
  output logic                 in_full,
  output logic                 req_valid,
  output switch_pkg::port_id_t req_dest,
  output logic                 tx_valid,
  output switch_pkg::port_id_t tx_dest,
  output switch_pkg::payload_t tx_data
);

  logic                    fifo_empty;
  switch_pkg::port_id_t    head_dest;
  switch_pkg::payload_t    head_data;
  switch_pkg::fifo_level_t fifo_level;
  switch_pkg::queue_state_t state;
  switch_pkg::queue_state_t state_next;

  // Input FIFO, popped by the grant
  pkt_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (in_valid),
    .rd_en   (grant),
    .wr_dest (in_dest),
    .wr_data (in_data),
    .rd_dest (head_dest),
    .rd_data (head_data),
    .empty   (fifo_empty),
    .full    (in_full),
    .level   (fifo_level)
  );

  // Request straight from the head word
  assign req_valid = !fifo_empty;
  assign req_dest  = head_dest;

  //////////////////////////////////////////////////////////////////////
  // Queue state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (grant)
      state_next = switch_pkg::Q_SEND;
    // FIFO holds a word after this edge
    else if (in_valid || (fifo_level != '0))
      state_next = switch_pkg::Q_REQ;
    else
      state_next = switch_pkg::Q_IDLE;
  end

  always_ff @(posedge clk) begin
    if (rst)
      state <= switch_pkg::Q_IDLE;
    else
      state <= state_next;
  end

  // Output register holds a packet only in the send state
  assign tx_valid = (state == switch_pkg::Q_SEND);

  // Payload stage, loaded on grant
  always_ff @(posedge clk) begin
    if (grant) begin
      tx_dest <= head_dest;
      tx_data <= head_data;
    end
  end

  // Sender honours the full level
  a_no_write_full : assert property (@(posedge clk) disable iff (rst)
    in_valid |-> !in_full);

  // Arbiter only grants a live request
  a_grant_has_req : assert property (@(posedge clk) disable iff (rst)
    grant |-> (req_valid && (state != switch_pkg::Q_IDLE)));

endmodule

//--- testbench/tb_packet_switch.sv
/* Self-checking testbench for packet_switch; the directed tests use ports 0 to 3,
   so SWITCH_PORTS must be at least 4 */
`timescale 1ns/1ps
`include "switch_cfg.svh"

module tb_packet_switch;

  localparam int NPORTS      = `SWITCH_PORTS;
  localparam int LATENCY     = 3;
  localparam int RAND_CYCLES = 200;
  localparam int RR_PKTS     = 6;
  localparam int RR_OUT      = 2;
  localparam int FULL_CYCLES = 4 * `SWITCH_FIFO_DEPTH;
  // Worst case every packet leaves through one output, one per cycle
  localparam int MAX_PKTS    = 2 + NPORTS * (RAND_CYCLES + RR_PKTS + FULL_CYCLES + 1);
  localparam int TIMEOUT_CYCLES = 2 * MAX_PKTS + 400;
  localparam logic [31:0] LFSR_SEED = 32'hdbdb_3f63;

  logic                                     clk = 1'b0;
  logic                                     rst;
  switch_pkg::port_mask_t                   in_valid;
  switch_pkg::port_id_t [`SWITCH_PORTS-1:0] in_dest;
  switch_pkg::payload_t [`SWITCH_PORTS-1:0] in_data;
  switch_pkg::port_mask_t                   in_full;
  switch_pkg::port_mask_t                   out_valid;
  switch_pkg::port_id_t [`SWITCH_PORTS-1:0] out_source;
  switch_pkg::payload_t [`SWITCH_PORTS-1:0] out_data;

  // Expected packets per source and destination pair, index src*NPORTS+dst
  switch_pkg::payload_t exp_data [NPORTS*NPORTS][$];
  int                   exp_edge [NPORTS*NPORTS][$];
  int                   rr_log[$];

  logic [31:0] lfsr = LFSR_SEED;
  int cycle = 0;
  int pending = 0;
  int errors = 0;
  int err_mark = 0;
  int sent = 0;
  int delivered = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic check_latency = 1'b0;
  logic rr_watch = 1'b0;

  packet_switch UUT (
    .clk (clk), .rst (rst),
    .in_valid (in_valid), .in_dest (in_dest), .in_data (in_data),
    .in_full (in_full),
    .out_valid (out_valid), .out_source (out_source), .out_data (out_data)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Oldest outstanding packet of a pair
  function automatic switch_pkg::payload_t expected_front(input int src, input int dst);
    return exp_data[src*NPORTS + dst][0];
  endfunction

  task automatic clear_inputs();
    in_valid = '0;
  endtask

  // Called on a falling edge; the DUT samples at the next rising edge
  task automatic queue_packet(input int src, input int dst, input switch_pkg::payload_t data);
    in_valid[src] = 1'b1;
    in_dest[src]  = switch_pkg::port_id_t'(dst);
    in_data[src]  = data;
    exp_data[src*NPORTS + dst].push_back(data);
    exp_edge[src*NPORTS + dst].push_back(cycle + 1);
    pending++;
    sent++;
  endtask

  task automatic clear_reference();
    for (int k = 0; k < NPORTS*NPORTS; k++) begin
      exp_data[k].delete();
      exp_edge[k].delete();
    end
    pending = 0;
  endtask

  // Watchdog catches packets that never come out
  task automatic wait_drained();
    while (pending != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic begin_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output comparison, on every rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : check_outputs
    int edge_no;
    int src;
    int idx;
    edge_no = cycle + 1;
    if (!rst) begin
      for (int j = 0; j < NPORTS; j++) begin
        if (out_valid[j] === 1'b1) begin
          src = int'(out_source[j]);
          idx = src*NPORTS + j;
          if (rr_watch && j == RR_OUT)
            rr_log.push_back(src);
          if (exp_data[idx].size() == 0) begin
            $display("unexpected packet on output %0d from input %0d at %0t", j, src, $time);
            errors++;
          end else begin
            if (out_data[j] !== expected_front(src, j)) begin
              $display("mismatch at %0t: output %0d from %0d data %h, expected %h",
                       $time, j, src, out_data[j], expected_front(src, j));
              errors++;
            end
            // Sampled at edge t, seen here at edge t+3
            if (check_latency && edge_no != exp_edge[idx][0] + LATENCY) begin
              $display("mismatch at %0t: output %0d latency %0d, expected %0d",
                       $time, j, edge_no - exp_edge[idx][0], LATENCY);
              errors++;
            end
            void'(exp_data[idx].pop_front());
            void'(exp_edge[idx].pop_front());
            pending--;
            delivered++;
          end
        end
      end
    end
    cycle = cycle + 1;
  end

  initial begin : watchdog
    wait (cycle >= TIMEOUT_CYCLES);
    $display("timeout: run stopped after %0d cycles with %0d packets undelivered",
             cycle, pending);
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    logic go;
    logic full_seen;
    int   dst;
    rst      = 1'b1;
    in_valid = '0;
    in_dest  = '0;
    in_data  = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // One packet, exact latency
    begin_test();
    check_latency = 1'b1;
    @(negedge clk);
    queue_packet(2, 1, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
    @(negedge clk);
    clear_inputs();
    wait_drained();
    check_latency = 1'b0;
    end_test("single_packet");

    // Random traffic from every input, honouring in_full
    begin_test();
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(negedge clk);
      clear_inputs();
      for (int i = 0; i < NPORTS; i++) begin
        go  = (take_bits(2) != '0);
        dst = int'(take_bits(`SWITCH_PORT_W));
        if (go && !in_full[i])
          queue_packet(i, dst, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
      end
    end
    @(negedge clk);
    clear_inputs();
    wait_drained();
    end_test("ordering");

    // All inputs contend for one output
    begin_test();
    rr_log.delete();
    rr_watch = 1'b1;
    for (int c = 0; c < RR_PKTS; c++) begin
      @(negedge clk);
      clear_inputs();
      for (int i = 0; i < NPORTS; i++)
        queue_packet(i, RR_OUT, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
    end
    @(negedge clk);
    clear_inputs();
    wait_drained();
    rr_watch = 1'b0;
    if (rr_log.size() != NPORTS*RR_PKTS) begin
      $display("round-robin output saw %0d packets instead of %0d",
               rr_log.size(), NPORTS*RR_PKTS);
      errors++;
    end
    // Each winner is the next port up, wrapping
    for (int k = 1; k < rr_log.size(); k++) begin
      if (rr_log[k] != (rr_log[k-1] + 1) % NPORTS) begin
        $display("mismatch at %0t: round-robin source %0d followed %0d",
                 $time, rr_log[k], rr_log[k-1]);
        errors++;
      end
    end
    end_test("round_robin");

    // Input 0 fills while its output is shared with three others
    begin_test();
    full_seen = 1'b0;
    for (int c = 0; c < FULL_CYCLES; c++) begin
      @(negedge clk);
      clear_inputs();
      if (in_full[0])
        full_seen = 1'b1;
      for (int i = 0; i < NPORTS; i++) begin
        if (!in_full[i])
          queue_packet(i, 1, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
      end
    end
    @(negedge clk);
    clear_inputs();
    wait_drained();
    if (!full_seen) begin
      $display("input 0 never raised in_full while its output was blocked");
      errors++;
    end
    end_test("full_flag");

    // Input i to output i, all in one cycle
    begin_test();
    check_latency = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NPORTS; i++)
      queue_packet(i, i, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
    @(negedge clk);
    clear_inputs();
    wait_drained();
    check_latency = 1'b0;
    end_test("parallel");

    // Packet in flight is dropped by reset, then the switch stays quiet
    begin_test();
    @(negedge clk);
    queue_packet(1, 3, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
    @(negedge clk);
    clear_inputs();
    rst = 1'b1;
    clear_reference();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      if (out_valid != '0) begin
        $display("output valid %b appeared after reset with nothing sent", out_valid);
        errors++;
      end
    end
    check_latency = 1'b1;
    queue_packet(3, 0, switch_pkg::payload_t'(take_bits(`SWITCH_DATA_W)));
    @(negedge clk);
    clear_inputs();
    wait_drained();
    check_latency = 1'b0;
    end_test("reset");

    $display("tests run %0d, failed %0d, packets sent %0d, delivered %0d, errors %0d",
             tests_run, tests_failed, sent, delivered, errors);
    if (errors == 0 && tests_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
